// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       := fetch_tb
FILELIST  := list.f
OBJDIR    := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qxF "STATUS: PASS"

clean:
	rm -rf $(OBJDIR)

// ==== hdl/axi_read_bridge.sv ====
`timescale 1ns/1ps

module axi_read_bridge (
  input  logic                   clk,
  input  logic                   rst,
  bus_if.responder               bus,
  output fetch_pkg::addr_t       araddr,
  output fetch_pkg::burst_len_t  arlen,
  output logic                   arvalid,
  input  logic                   arready,
  input  fetch_pkg::word_t       rdata,
  input  logic                   rlast,
  input  logic                   rvalid,
  output logic                   rready
);
  import fetch_pkg::*;

  bridge_state_t state;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= br_idle;
    end else begin
      case (state)
        br_idle: begin
          if (bus.req) begin
            state <= br_addr;
          end
        end
        br_addr: begin
          // address held until the slave takes it
          if (arready) begin
            state <= br_data;
          end
        end
        br_data: begin
          if (rvalid && rlast) begin
            state <= br_idle;
          end
        end
        default: begin
          state <= br_idle;
        end
      endcase
    end
  end

  // latch the burst on the take
  always_ff @(posedge clk) begin
    if (state == br_idle && bus.req) begin
      araddr <= bus.addr;
      arlen  <= bus.len;
    end
  end

  assign bus.addr_ok = (state == br_idle);
  assign arvalid     = (state == br_addr);
  assign rready      = (state == br_data);

  // R beats pass through in the same cycle
  assign bus.beat  = rready & rvalid;
  assign bus.last  = rready & rvalid & rlast;
  assign bus.rdata = rdata;

endmodule

// ==== hdl/fetch_pkg.sv ====
package fetch_pkg;

  // address and data widths
  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;

  // address split: tag [31:8], index [7:4], word offset [3:2]
  typedef logic [23:0] tag_t;
  typedef logic [3:0]  index_t;
  typedef logic [1:0]  beat_t;

  // AXI burst length field
  typedef logic [7:0]  burst_len_t;

  // cache geometry
  localparam int LINE_WORDS = 4;
  localparam int NUM_LINES  = 16;

  // kseg1 is fetched around the cache
  localparam logic [2:0] UNCACHED_SEG = 3'b101;

  typedef enum logic [2:0] {
    cs_idle,
    cs_lookup,
    cs_refill_req,
    cs_refill,
    cs_bypass_req,
    cs_bypass_wait,
    cs_respond
  } cache_state_t;

  typedef enum logic [1:0] {
    br_idle,
    br_addr,
    br_data
  } bridge_state_t;

endpackage

// ==== hdl/fetch_port.sv ====
`timescale 1ns/1ps

module fetch_port (
  input  logic             clk,
  input  logic             rst,
  input  logic             inst_req,
  input  fetch_pkg::addr_t inst_addr,
  output logic             inst_addr_ok,
  output logic             inst_data_ok,
  output fetch_pkg::word_t inst_rdata,
  fetch_if.requester       fetch
);
  import fetch_pkg::*;

  logic  busy;
  logic  pend;
  addr_t buf_addr;
  logic  buf_cached;
  logic  take;

  // one fetch in flight at a time
  assign inst_addr_ok = ~busy;
  assign take         = inst_req & inst_addr_ok;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
      pend <= 1'b0;
    end else begin
      if (take) begin
        busy <= 1'b1;
        pend <= 1'b1;
      end else if (fetch.data_ok) begin
        busy <= 1'b0;
      end
      // request leaves once the cache has it
      if (pend && fetch.addr_ok) begin
        pend <= 1'b0;
      end
    end
  end

  // request buffer
  always_ff @(posedge clk) begin
    if (take) begin
      buf_addr   <= inst_addr;
      buf_cached <= (inst_addr[31:29] != UNCACHED_SEG);
    end
  end

  assign fetch.req    = pend;
  assign fetch.addr   = buf_addr;
  assign fetch.cached = buf_cached;

  // answer goes straight back to the core
  assign inst_data_ok = fetch.data_ok;
  assign inst_rdata   = fetch.rdata;

endmodule

// ==== hdl/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top (
  input  logic                   clk,
  input  logic                   rst,
  // core side, sram-like
  input  logic                   inst_req,
  input  fetch_pkg::addr_t       inst_addr,
  output logic                   inst_addr_ok,
  output logic                   inst_data_ok,
  output fetch_pkg::word_t       inst_rdata,
  // AXI read channels
  output fetch_pkg::addr_t       araddr,
  output fetch_pkg::burst_len_t  arlen,
  output logic                   arvalid,
  input  logic                   arready,
  input  fetch_pkg::word_t       rdata,
  input  logic                   rlast,
  input  logic                   rvalid,
  output logic                   rready
);

  fetch_if fetch ();
  bus_if   bus ();

  fetch_port u_fetch_port (
    .clk          (clk),
    .rst          (rst),
    .inst_req     (inst_req),
    .inst_addr    (inst_addr),
    .inst_addr_ok (inst_addr_ok),
    .inst_data_ok (inst_data_ok),
    .inst_rdata   (inst_rdata),
    .fetch        (fetch.requester)
  );

  icache u_icache (
    .clk   (clk),
    .rst   (rst),
    .fetch (fetch.responder),
    .bus   (bus.requester)
  );

  axi_read_bridge u_axi_read_bridge (
    .clk     (clk),
    .rst     (rst),
    .bus     (bus.responder),
    .araddr  (araddr),
    .arlen   (arlen),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rlast   (rlast),
    .rvalid  (rvalid),
    .rready  (rready)
  );

endmodule

// ==== hdl/icache.sv ====
`timescale 1ns/1ps

module icache (
  input  logic       clk,
  input  logic       rst,
  fetch_if.responder fetch,
  bus_if.requester   bus
);
  import fetch_pkg::*;

  cache_state_t state;

  logic [NUM_LINES-1:0] valid_q;
  tag_t                 tag_mem  [NUM_LINES];
  word_t                data_mem [NUM_LINES][LINE_WORDS];

  addr_t  req_addr;
  tag_t   req_tag;
  index_t req_index;
  beat_t  req_beat;
  beat_t  refill_cnt;
  word_t  resp_data;
  logic   hit;
  logic   take;
  logic   bus_take;

  assign req_tag   = req_addr[31:8];
  assign req_index = req_addr[7:4];
  assign req_beat  = req_addr[3:2];

  assign hit      = valid_q[req_index] && (tag_mem[req_index] == req_tag);
  assign take     = fetch.req && fetch.addr_ok;
  assign bus_take = bus.req && bus.addr_ok;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= cs_idle;
      valid_q    <= '0;
      refill_cnt <= '0;
    end else begin
      case (state)
        cs_idle: begin
          if (take) begin
            state <= fetch.cached ? cs_lookup : cs_bypass_req;
          end
        end
        cs_lookup: begin
          // a hit answers here and goes back to idle
          state <= hit ? cs_idle : cs_refill_req;
        end
        cs_refill_req: begin
          if (bus_take) begin
            state      <= cs_refill;
            refill_cnt <= '0;
          end
        end
        cs_refill: begin
          if (bus.beat) begin
            refill_cnt <= refill_cnt + 1'b1;
            if (bus.last) begin
              valid_q[req_index] <= 1'b1;
              state              <= cs_respond;
            end
          end
        end
        cs_bypass_req: begin
          if (bus_take) begin
            state <= cs_bypass_wait;
          end
        end
        cs_bypass_wait: begin
          if (bus.beat && bus.last) begin
            state <= cs_respond;
          end
        end
        cs_respond: begin
          state <= cs_idle;
        end
        default: begin
          state <= cs_idle;
        end
      endcase
    end
  end

  // request address, line arrays and returned word
  always_ff @(posedge clk) begin
    if (take) begin
      req_addr <= fetch.addr;
    end
    if (state == cs_refill && bus.beat) begin
      data_mem[req_index][refill_cnt] <= bus.rdata;
      if (refill_cnt == req_beat) begin
        resp_data <= bus.rdata;
      end
      if (bus.last) begin
        tag_mem[req_index] <= req_tag;
      end
    end
    // uncached word is not kept
    if (state == cs_bypass_wait && bus.beat) begin
      resp_data <= bus.rdata;
    end
  end

  assign fetch.addr_ok = (state == cs_idle);
  assign fetch.data_ok = (state == cs_lookup && hit) || (state == cs_respond);
  assign fetch.rdata   = (state == cs_lookup) ? data_mem[req_index][req_beat] : resp_data;

  // line refill reads the aligned line, bypass reads one word
  assign bus.req  = (state == cs_refill_req) || (state == cs_bypass_req);
  assign bus.addr = (state == cs_refill_req) ? {req_tag, req_index, 4'b0000} : req_addr;
  assign bus.len  = (state == cs_refill_req) ? burst_len_t'(LINE_WORDS - 1) : '0;

endmodule

// ==== hdl/mem_ifs.sv ====
`timescale 1ns/1ps

// fetch request path, port side to cache
interface fetch_if;
  import fetch_pkg::*;

  logic  req;
  addr_t addr;
  logic  cached;
  logic  addr_ok;
  logic  data_ok;
  word_t rdata;

  modport requester (
    output req, addr, cached,
    input  addr_ok, data_ok, rdata
  );

  modport responder (
    input  req, addr, cached,
    output addr_ok, data_ok, rdata
  );

endinterface

// burst read path, cache to AXI bridge
interface bus_if;
  import fetch_pkg::*;

  logic       req;
  addr_t      addr;
  burst_len_t len;
  logic       addr_ok;
  logic       beat;
  word_t      rdata;
  logic       last;

  modport requester (
    output req, addr, len,
    input  addr_ok, beat, rdata, last
  );

  modport responder (
    input  req, addr, len,
    output addr_ok, beat, rdata, last
  );

endinterface

// ==== list.f ====
hdl/fetch_pkg.sv
hdl/mem_ifs.sv
hdl/fetch_port.sv
hdl/icache.sv
hdl/axi_read_bridge.sv
hdl/fetch_top.sv
tb/fetch_checker.sv
tb/fetch_tb.sv

// ==== tb/fetch_checker.sv ====
`timescale 1ns/1ps

module fetch_checker (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  inst_req,
  input  fetch_pkg::addr_t      inst_addr,
  input  logic                  inst_addr_ok,
  input  logic                  inst_data_ok,
  input  fetch_pkg::word_t      inst_rdata,
  input  fetch_pkg::addr_t      araddr,
  input  fetch_pkg::burst_len_t arlen,
  input  logic                  arvalid,
  input  logic                  arready,
  input  logic                  rready,
  input  logic [7:0]            epoch,
  output int                    pass_count,
  output int                    fail_count
);
  import fetch_pkg::*;

  // name of the running test, set by the stimulus loop
  string test_name;

  // shadow of the cache lines
  logic [15:0] sh_valid;
  tag_t        sh_tag   [16];
  logic [7:0]  sh_epoch [16];

  int         cycle;
  int         take_cycle;
  int         ar_count;
  addr_t      cur_addr;
  addr_t      ar_addr;
  burst_len_t ar_len;
  logic       in_flight;
  logic       started;
  logic       idle_bad;

  always @(posedge clk) begin
    word_t  exp_word;
    index_t idx;
    logic   hit;
    logic   ar_ok;
    logic   lat_ok;
    if (rst) begin
      cycle      <= 0;
      sh_valid   <= '0;
      in_flight  <= 1'b0;
      started    <= 1'b0;
      idle_bad   <= 1'b0;
      ar_count   <= 0;
      pass_count <= 0;
      fail_count <= 0;
    end else begin
      cycle <= cycle + 1;
      if (!started && (arvalid || rready || inst_data_ok || !inst_addr_ok)) begin
        idle_bad <= 1'b1;
      end
      if (arvalid && arready) begin
        ar_count <= ar_count + 1;
        ar_addr  <= araddr;
        ar_len   <= arlen;
      end
      if (inst_req && inst_addr_ok) begin
        // first take closes the idle check after reset
        if (!started) begin
          if (idle_bad || arvalid || rready || inst_data_ok) begin
            $display("fail reset_idle: bus or core handshake active before the first request");
            fail_count <= fail_count + 1;
          end else begin
            $display("pass reset_idle");
            pass_count <= pass_count + 1;
          end
        end
        started    <= 1'b1;
        in_flight  <= 1'b1;
        cur_addr   <= inst_addr;
        take_cycle <= cycle;
        ar_count   <= 0;
      end
      if (inst_data_ok && !in_flight) begin
        $display("fail %s: inst_data_ok with no fetch in flight", test_name);
        fail_count <= fail_count + 1;
      end else if (inst_data_ok) begin
        in_flight <= 1'b0;
        idx    = cur_addr[7:4];
        ar_ok  = 1'b1;
        lat_ok = 1'b1;
        if (cur_addr[31:29] != 3'b101) begin
          hit = sh_valid[idx] && (sh_tag[idx] == cur_addr[31:8]);
          if (hit) begin
            ar_ok    = (ar_count == 0);
            lat_ok   = ((cycle - take_cycle) == 2);
            exp_word = {cur_addr[31:2], 2'b00} ^ {4{sh_epoch[idx]}};
          end else begin
            ar_ok = (ar_count == 1) && (ar_len == 8'd3) &&
                    (ar_addr == {cur_addr[31:4], 4'b0000});
            sh_valid[idx] <= 1'b1;
            sh_tag[idx]   <= cur_addr[31:8];
            sh_epoch[idx] <= epoch;
            exp_word = {cur_addr[31:2], 2'b00} ^ {4{epoch}};
          end
        end else begin
          // kseg1 goes around the cache
          ar_ok    = (ar_count == 1) && (ar_len == 8'd0) && (ar_addr == cur_addr);
          exp_word = {cur_addr[31:2], 2'b00} ^ {4{epoch}};
        end
        if (inst_rdata !== exp_word) begin
          $display("error %s: expected %h, actual %h", test_name, exp_word, inst_rdata);
          fail_count <= fail_count + 1;
        end else if (!ar_ok) begin
          $display("fail %s: wrong AR traffic, %0d bursts, last at %h with length %0d",
                   test_name, ar_count, ar_addr, ar_len);
          fail_count <= fail_count + 1;
        end else if (!lat_ok) begin
          $display("fail %s: hit answered %0d cycles after the take instead of 2",
                   test_name, cycle - take_cycle);
          fail_count <= fail_count + 1;
        end else begin
          $display("pass %s: %h", test_name, inst_rdata);
          pass_count <= pass_count + 1;
        end
      end
    end
  end

endmodule

// ==== tb/fetch_tb.sv ====
`timescale 1ns/1ps

module fetch_tb;
  import fetch_pkg::*;

  localparam int N = 12;

  // test name, fetch address, epoch advance before the fetch
  string names [N] = '{
    "first_miss", "same_line_hit", "uncached", "uncached_new_epoch",
    "hit_old_epoch", "conflict_refill", "return_refill", "line2_miss",
    "line2_hit", "boot_uncached", "kseg0_miss", "kseg0_hit_new_epoch"
  };
  addr_t addrs [N] = '{
    32'h0000_1004, 32'h0000_1008, 32'hA000_2010, 32'hA000_2010,
    32'h0000_100C, 32'h0001_1004, 32'h0000_1000, 32'h0000_2030,
    32'h0000_2034, 32'hBFC0_0000, 32'h8000_0040, 32'h8000_004C
  };
  logic advance [N] = '{0, 0, 0, 1, 0, 0, 1, 0, 0, 0, 0, 1};

  logic       clk;
  logic       rst;
  logic       inst_req;
  addr_t      inst_addr;
  logic       inst_addr_ok;
  logic       inst_data_ok;
  word_t      inst_rdata;
  addr_t      araddr;
  burst_len_t arlen;
  logic       arvalid;
  logic       arready = 1'b0;
  word_t      rdata   = '0;
  logic       rlast   = 1'b0;
  logic       rvalid  = 1'b0;
  logic       rready;
  logic [7:0] epoch;

  integer     seed = 32'h8dc9d638;
  logic       bursting = 1'b0;
  addr_t      beat_addr;
  burst_len_t beats_left;
  int         pass_count;
  int         fail_count;

  fetch_top UUT (
    .clk          (clk),
    .rst          (rst),
    .inst_req     (inst_req),
    .inst_addr    (inst_addr),
    .inst_addr_ok (inst_addr_ok),
    .inst_data_ok (inst_data_ok),
    .inst_rdata   (inst_rdata),
    .araddr       (araddr),
    .arlen        (arlen),
    .arvalid      (arvalid),
    .arready      (arready),
    .rdata        (rdata),
    .rlast        (rlast),
    .rvalid       (rvalid),
    .rready       (rready)
  );

  fetch_checker u_checker (
    .clk          (clk),
    .rst          (rst),
    .inst_req     (inst_req),
    .inst_addr    (inst_addr),
    .inst_addr_ok (inst_addr_ok),
    .inst_data_ok (inst_data_ok),
    .inst_rdata   (inst_rdata),
    .araddr       (araddr),
    .arlen        (arlen),
    .arvalid      (arvalid),
    .arready      (arready),
    .rready       (rready),
    .epoch        (epoch),
    .pass_count   (pass_count),
    .fail_count   (fail_count)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // AXI slave, word = aligned address xor epoch in every byte
  always @(posedge clk) begin
    addr_t      next_addr;
    burst_len_t next_left;
    arready <= (($random(seed) & 3) != 0);
    if (!rst && !bursting && arvalid && arready) begin
      bursting   <= 1'b1;
      beat_addr  <= {araddr[31:2], 2'b00};
      beats_left <= arlen;
    end else if (!rst && bursting) begin
      next_addr = beat_addr;
      next_left = beats_left;
      if (rvalid && rready) begin
        next_addr = beat_addr + 32'd4;
        next_left = beats_left - 8'd1;
      end
      if (rvalid && rready && rlast) begin
        bursting <= 1'b0;
        rvalid   <= 1'b0;
        rlast    <= 1'b0;
      end else if (rvalid && !rready) begin
        // beat held until taken
      end else if (($random(seed) & 3) != 0) begin
        rvalid <= 1'b1;
        rdata  <= {next_addr[31:2], 2'b00} ^ {4{epoch}};
        rlast  <= (next_left == 8'd0);
      end else begin
        rvalid <= 1'b0;
      end
      beat_addr  <= next_addr;
      beats_left <= next_left;
    end
  end

  initial begin
    rst       = 1'b1;
    inst_req  = 1'b0;
    inst_addr = '0;
    epoch     = 8'h3c;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    repeat (3) @(posedge clk);
    for (int i = 0; i < N; i++) begin
      @(posedge clk);
      u_checker.test_name = names[i];
      if (advance[i]) begin
        epoch <= epoch + 8'd1;
      end
      inst_req  <= 1'b1;
      inst_addr <= addrs[i];
      do @(posedge clk); while (!inst_addr_ok);
      inst_req <= 1'b0;
      do @(posedge clk); while (!inst_data_ok);
    end
    repeat (2) @(posedge clk);
    $display("tests passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0 && pass_count == N + 1) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(N * 200 * 40);
    $display("timeout, the fetch sequence did not finish");
    $display("STATUS: FAIL");
    $finish;
  end

endmodule
